/* logic/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

  // Address split of a 32-bit byte address into tag, set and line offset
  localparam int offset_bits    = 6;
  localparam int set_bits       = 5;
  localparam int way_bits       = 2;
  localparam int tag_bits       = 21;
  localparam int line_words     = 16;
  localparam int data_addr_bits = 9;

  typedef logic [way_bits-1:0] way_t;
  typedef logic [set_bits-1:0] set_t;

  // One tag RAM entry, the upper bits always read as zero
  typedef struct packed {
    logic [31-tag_bits-2:0] pad;
    logic                   dirty;
    logic                   valid;
    logic [tag_bits-1:0]    tag;
  } tag_word_t;

  typedef enum logic [1:0] {req_nop, req_io, req_fill, req_init} req_kind_t;

  // Phases that the controller hands to the line mover
  typedef enum logic [1:0] {mode_io, mode_wb, mode_fill, mode_init} xfer_mode_t;

endpackage

`default_nettype wire

/* logic/cache_bus_pkg.sv */
`default_nettype none

package cache_bus_pkg;

  // Avalon master widths
  localparam int addr_bits = 32;
  localparam int data_bits = 32;
  localparam int be_bits   = 4;

  // Every line transfer is one burst of a full line
  localparam int burst_len  = 16;
  localparam int burst_bits = 5;

  localparam int cmd_fifo_depth = 2;

  // One queued Avalon command
  typedef struct packed {
    logic [addr_bits-1:0]  address;
    logic [be_bits-1:0]    byte_en;
    logic                  read;
    logic                  write;
    logic [data_bits-1:0]  wdata;
    logic                  begin_burst;
    logic [burst_bits-1:0] burst_count;
  } bus_cmd_t;

endpackage

`default_nettype wire

/* logic/cache_if.sv */
`default_nettype none

// Command path from the line mover into the bus command FIFO
interface bus_cmd_if;
  logic                    push;
  cache_bus_pkg::bus_cmd_t cmd;
  logic                    full;
  logic                    empty;

  modport producer (output push, output cmd, input full, input empty);
  modport fifo (input push, input cmd, output full, output empty);
endinterface

// Phase handoff from the request FSM to the line mover
interface xfer_if;
  logic                                     start;
  cache_geom_pkg::xfer_mode_t               mode;
  cache_geom_pkg::way_t                     way;
  logic [cache_bus_pkg::addr_bits-1:0]      line_addr;
  logic [cache_bus_pkg::addr_bits-1:0]      io_address;
  logic                                     io_read;
  logic                                     io_write;
  logic [cache_bus_pkg::data_bits-1:0]      io_wdata;
  logic [cache_bus_pkg::be_bits-1:0]        io_byte_en;
  logic                                     busy;

  modport controller (output start, output mode, output way, output line_addr,
                      output io_address, output io_read, output io_write,
                      output io_wdata, output io_byte_en, input busy);
  modport mover (input start, input mode, input way, input line_addr,
                 input io_address, input io_read, input io_write,
                 input io_wdata, input io_byte_en, output busy);
endinterface

`default_nettype wire

/* logic/bus_cmd_fifo.sv */
`default_nettype none

module bus_cmd_fifo (
  input  logic                    clk,
  input  logic                    rest,
  bus_cmd_if.fifo                 bus,
  output cache_bus_pkg::bus_cmd_t head,
  output logic                    valid,
  input  logic                    pop
);

  cache_bus_pkg::bus_cmd_t mem [cache_bus_pkg::cmd_fifo_depth];
  logic [$clog2(cache_bus_pkg::cmd_fifo_depth)-1:0] rd_ptr;
  logic [$clog2(cache_bus_pkg::cmd_fifo_depth)-1:0] wr_ptr;
  logic [$clog2(cache_bus_pkg::cmd_fifo_depth+1)-1:0] count;
  logic take;
  logic store;

  assign bus.empty = count == '0;
  assign bus.full  = count == ($bits(count))'(cache_bus_pkg::cmd_fifo_depth);

  // An empty FIFO shows the incoming command at once
  assign valid = !bus.empty || bus.push;
  assign head  = bus.empty ? bus.cmd : mem[rd_ptr];

  assign take  = pop && !bus.empty;
  // A command that bypasses straight to the bus is never stored
  assign store = bus.push && !(bus.empty && pop);

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_ptr] <= bus.cmd;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (store) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + ($bits(count))'(store) - ($bits(count))'(take);
    end
  end

  // A push into a full FIFO is only safe while its head leaves in the same cycle
  assert property (@(posedge clk) disable iff (!rest)
    bus.push && bus.full |-> pop)
    else $error("command pushed into a full FIFO that was not draining");

endmodule

`default_nettype wire

/* logic/victim_select.sv */
`default_nettype none

module victim_select (
  input  logic                 clk,
  input  logic                 rest,
  input  logic                 free_valid,
  input  cache_geom_pkg::way_t free_way,
  input  cache_geom_pkg::set_t victim_set,
  input  logic                 victim_take,
  output cache_geom_pkg::way_t victim_way
);

  // Round-robin pointer per set
  cache_geom_pkg::way_t rr [2**cache_geom_pkg::set_bits];

  // A free way always wins over eviction
  assign victim_way = free_valid ? free_way : rr[victim_set];

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int i = 0; i < 2**cache_geom_pkg::set_bits; i++) begin
        rr[i] <= '0;
      end
    end else if (victim_take && !free_valid) begin
      rr[victim_set] <= rr[victim_set] + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/xfer_ctrl.sv */
`default_nettype none

module xfer_ctrl (
  input  logic                                clk,
  input  logic                                rest,
  input  cache_geom_pkg::req_kind_t           req_kind,
  input  logic [cache_bus_pkg::addr_bits-1:0] req_address,
  input  logic                                req_read,
  input  logic                                req_write,
  input  logic [cache_bus_pkg::data_bits-1:0] req_wdata,
  input  logic [cache_bus_pkg::be_bits-1:0]   req_byte_en,
  input  cache_geom_pkg::tag_word_t           tag_read_data,
  input  cache_geom_pkg::way_t                victim_way,
  output logic                                req_done,
  output cache_geom_pkg::set_t                tag_read_set,
  output cache_geom_pkg::way_t                tag_read_way,
  output cache_geom_pkg::set_t                victim_set,
  output logic                                victim_take,
  xfer_if.controller                          x
);

  typedef enum logic [2:0] {
    st_idle, st_io, st_look_addr, st_look_data, st_wb, st_fill, st_init
  } state_t;

  state_t                                   state;
  cache_geom_pkg::way_t                     way_q;
  cache_geom_pkg::set_t                     req_set;
  logic [cache_geom_pkg::tag_bits-1:0]      req_tag;
  logic [cache_bus_pkg::addr_bits-1:0]      new_line;
  logic                                     phase_end;

  assign req_set  = req_address[cache_geom_pkg::offset_bits +: cache_geom_pkg::set_bits];
  assign req_tag  = req_address[cache_bus_pkg::addr_bits-1 -: cache_geom_pkg::tag_bits];
  assign new_line = {req_tag, req_set, {cache_geom_pkg::offset_bits{1'b0}}};

  assign victim_set   = req_set;
  assign victim_take  = state == st_idle && req_kind == cache_geom_pkg::req_fill;
  assign tag_read_set = req_set;
  assign tag_read_way = way_q;

  // Io fields stay stable for the whole request
  assign x.way        = way_q;
  assign x.io_address = req_address;
  assign x.io_read    = req_read;
  assign x.io_write   = req_write;
  assign x.io_wdata   = req_wdata;
  assign x.io_byte_en = req_byte_en;

  // Busy rises one cycle after start, so both must be low
  assign phase_end = !x.start && !x.busy;
  assign req_done  = phase_end && (state == st_io || state == st_fill || state == st_init);

  // ==========================================================
  // Request FSM
  // ==========================================================
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state       <= st_idle;
      way_q       <= '0;
      x.start     <= 1'b0;
      x.mode      <= cache_geom_pkg::mode_io;
      x.line_addr <= '0;
    end else begin
      x.start <= 1'b0;
      case (state)
        st_idle: begin
          case (req_kind)
            cache_geom_pkg::req_io: begin
              x.start <= 1'b1;
              x.mode  <= cache_geom_pkg::mode_io;
              state   <= st_io;
            end
            cache_geom_pkg::req_fill: begin
              way_q <= victim_way;
              state <= st_look_addr;
            end
            cache_geom_pkg::req_init: begin
              x.start <= 1'b1;
              x.mode  <= cache_geom_pkg::mode_init;
              state   <= st_init;
            end
            default: begin
              state <= st_idle;
            end
          endcase
        end
        st_look_addr: begin
          state <= st_look_data;
        end
        st_look_data: begin
          x.start <= 1'b1;
          // Only a valid and modified line has to go back to memory
          if (tag_read_data.valid && tag_read_data.dirty) begin
            x.mode      <= cache_geom_pkg::mode_wb;
            x.line_addr <= {tag_read_data.tag, req_set, {cache_geom_pkg::offset_bits{1'b0}}};
            state       <= st_wb;
          end else begin
            x.mode      <= cache_geom_pkg::mode_fill;
            x.line_addr <= new_line;
            state       <= st_fill;
          end
        end
        st_wb: begin
          if (phase_end) begin
            x.start     <= 1'b1;
            x.mode      <= cache_geom_pkg::mode_fill;
            x.line_addr <= new_line;
            state       <= st_fill;
          end
        end
        default: begin
          if (phase_end) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // The done logic counts on busy following start by exactly one cycle
  assert property (@(posedge clk) disable iff (!rest)
    x.start |=> x.busy)
    else $error("line mover did not turn busy after start");

endmodule

`default_nettype wire

/* logic/line_mover.sv */
`default_nettype none

module line_mover (
  input  logic                                     clk,
  input  logic                                     rest,
  input  logic [cache_bus_pkg::data_bits-1:0]      data_read_data,
  input  logic [cache_bus_pkg::data_bits-1:0]      av_read_data,
  input  logic                                     av_read_data_valid,
  output logic [cache_geom_pkg::data_addr_bits-1:0] data_read_addr,
  output cache_geom_pkg::way_t                     data_read_way,
  output logic [cache_geom_pkg::data_addr_bits-1:0] data_write_addr,
  output cache_geom_pkg::way_t                     data_write_way,
  output logic [cache_bus_pkg::data_bits-1:0]      data_write_data,
  output logic                                     data_write_en,
  output cache_geom_pkg::set_t                     tag_write_set,
  output cache_geom_pkg::way_t                     tag_write_way,
  output cache_geom_pkg::tag_word_t                tag_write_data,
  output logic                                     tag_write_en,
  output logic [cache_bus_pkg::data_bits-1:0]      req_rdata,
  xfer_if.mover                                    x,
  bus_cmd_if.producer                              bus
);

  // Words read from RAM, commands pushed and words returned
  logic [4:0] rd_cnt, push_cnt, ret_cnt;
  logic [cache_geom_pkg::set_bits+cache_geom_pkg::way_bits:0] init_cnt;
  logic                                   rd_issue, rd_pending, hold_valid;
  logic                                   arrive, init_wr, finish;
  logic [cache_bus_pkg::data_bits-1:0]    hold_data;
  cache_geom_pkg::set_t                   line_set;

  assign line_set       = x.line_addr[cache_geom_pkg::offset_bits +: cache_geom_pkg::set_bits];
  assign data_read_addr = {line_set, rd_cnt[3:0]};
  assign data_read_way  = x.way;
  assign data_write_way = x.way;

  assign arrive  = x.busy && x.mode == cache_geom_pkg::mode_fill && av_read_data_valid;
  assign init_wr = x.busy && x.mode == cache_geom_pkg::mode_init &&
                   !init_cnt[cache_geom_pkg::set_bits+cache_geom_pkg::way_bits];
  // A new RAM read only when the hold register is sure to be free on its return
  assign rd_issue = x.busy && x.mode == cache_geom_pkg::mode_wb && !rd_pending &&
                    rd_cnt < cache_geom_pkg::line_words && (!hold_valid || bus.push);

  // ==========================================================
  // Bus command build
  // ==========================================================
  always_comb begin
    bus.push            = 1'b0;
    bus.cmd             = '0;
    bus.cmd.address     = x.line_addr + (cache_bus_pkg::addr_bits'(push_cnt) << 2);
    bus.cmd.byte_en     = '1;
    bus.cmd.begin_burst = push_cnt == '0;
    bus.cmd.burst_count = cache_bus_pkg::burst_bits'(cache_bus_pkg::burst_len);
    case (x.mode)
      cache_geom_pkg::mode_io: begin
        bus.push            = x.busy && push_cnt == '0 && !bus.full;
        bus.cmd.address     = x.io_address;
        bus.cmd.byte_en     = x.io_byte_en;
        bus.cmd.read        = x.io_read;
        bus.cmd.write       = x.io_write;
        bus.cmd.wdata       = x.io_wdata;
        bus.cmd.begin_burst = 1'b0;
        bus.cmd.burst_count = cache_bus_pkg::burst_bits'(1);
      end
      cache_geom_pkg::mode_wb: begin
        bus.push      = x.busy && hold_valid && !bus.full;
        bus.cmd.write = 1'b1;
        bus.cmd.wdata = hold_data;
      end
      cache_geom_pkg::mode_fill: begin
        bus.push     = x.busy && push_cnt < cache_bus_pkg::burst_len && !bus.full;
        bus.cmd.read = 1'b1;
      end
      default: begin
        bus.push = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (x.mode)
      cache_geom_pkg::mode_io:
        finish = push_cnt != '0 && (x.io_read ? av_read_data_valid : bus.empty);
      cache_geom_pkg::mode_wb:
        finish = push_cnt == cache_bus_pkg::burst_len && bus.empty;
      cache_geom_pkg::mode_fill:
        finish = data_write_en && ret_cnt == cache_geom_pkg::line_words;
      default:
        finish = init_cnt[cache_geom_pkg::set_bits+cache_geom_pkg::way_bits];
    endcase
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      x.busy        <= 1'b0;
      rd_cnt        <= '0;
      push_cnt      <= '0;
      ret_cnt       <= '0;
      init_cnt      <= '0;
      rd_pending    <= 1'b0;
      hold_valid    <= 1'b0;
      data_write_en <= 1'b0;
      tag_write_en  <= 1'b0;
    end else begin
      rd_pending    <= rd_issue;
      data_write_en <= arrive;
      // The fill tag goes out together with the first data word
      tag_write_en  <= (arrive && ret_cnt == '0) || init_wr;
      if (x.start) begin
        x.busy   <= 1'b1;
        rd_cnt   <= '0;
        push_cnt <= '0;
        ret_cnt  <= '0;
        init_cnt <= '0;
      end else begin
        if (finish) x.busy <= 1'b0;
        if (rd_issue) rd_cnt <= rd_cnt + 1'b1;
        if (bus.push) push_cnt <= push_cnt + 1'b1;
        if (arrive) ret_cnt <= ret_cnt + 1'b1;
        if (init_wr) init_cnt <= init_cnt + 1'b1;
      end
      if (rd_pending) begin
        hold_valid <= 1'b1;
      end else if (bus.push && x.mode == cache_geom_pkg::mode_wb) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) hold_data <= data_read_data;
    if (arrive) begin
      data_write_addr <= {line_set, ret_cnt[3:0]};
      data_write_data <= av_read_data;
    end
    if (x.busy && x.mode == cache_geom_pkg::mode_io && av_read_data_valid) begin
      req_rdata <= av_read_data;
    end
    if (x.mode == cache_geom_pkg::mode_init) begin
      {tag_write_way, tag_write_set} <=
        init_cnt[cache_geom_pkg::set_bits+cache_geom_pkg::way_bits-1:0];
      tag_write_data <= '0;
    end else begin
      tag_write_way  <= x.way;
      tag_write_set  <= line_set;
      tag_write_data <= '{pad: '0, dirty: 1'b0, valid: 1'b1,
                          tag: x.line_addr[cache_bus_pkg::addr_bits-1 -: cache_geom_pkg::tag_bits]};
    end
  end

  // Fill data can only come back for a read that has already been pushed
  assert property (@(posedge clk) disable iff (!rest) arrive |-> ret_cnt < push_cnt)
    else $error("fill data returned without an outstanding read");

endmodule

`default_nettype wire

/* logic/cache_refill.sv */
`default_nettype none

module cache_refill (
  input  logic                                      clk,
  input  logic                                      rest,
  input  cache_geom_pkg::req_kind_t                 req_kind,
  input  logic [cache_bus_pkg::addr_bits-1:0]       req_address,
  input  logic                                      req_read,
  input  logic                                      req_write,
  input  logic [cache_bus_pkg::data_bits-1:0]       req_wdata,
  input  logic [cache_bus_pkg::be_bits-1:0]         req_byte_en,
  input  logic                                      free_valid,
  input  cache_geom_pkg::way_t                      free_way,
  output logic                                      req_done,
  output logic [cache_bus_pkg::data_bits-1:0]       req_rdata,
  output logic [cache_bus_pkg::addr_bits-1:0]       av_address,
  output logic [cache_bus_pkg::be_bits-1:0]         av_byte_en,
  output logic                                      av_read,
  output logic                                      av_write,
  output logic [cache_bus_pkg::data_bits-1:0]       av_wdata,
  output logic                                      av_begin_burst,
  output logic [cache_bus_pkg::burst_bits-1:0]      av_burst_count,
  input  logic                                      av_wait_request,
  input  logic [cache_bus_pkg::data_bits-1:0]       av_read_data,
  input  logic                                      av_read_data_valid,
  output logic [cache_geom_pkg::data_addr_bits-1:0] data_read_addr,
  output cache_geom_pkg::way_t                      data_read_way,
  input  logic [cache_bus_pkg::data_bits-1:0]       data_read_data,
  output logic [cache_geom_pkg::data_addr_bits-1:0] data_write_addr,
  output cache_geom_pkg::way_t                      data_write_way,
  output logic [cache_bus_pkg::data_bits-1:0]       data_write_data,
  output logic                                      data_write_en,
  output cache_geom_pkg::set_t                      tag_read_set,
  output cache_geom_pkg::way_t                      tag_read_way,
  input  cache_geom_pkg::tag_word_t                 tag_read_data,
  output cache_geom_pkg::set_t                      tag_write_set,
  output cache_geom_pkg::way_t                      tag_write_way,
  output cache_geom_pkg::tag_word_t                 tag_write_data,
  output logic                                      tag_write_en
);

  xfer_if    xfer ();
  bus_cmd_if bus_cmd ();

  cache_bus_pkg::bus_cmd_t head;
  logic                    head_valid;
  cache_geom_pkg::set_t    victim_set;
  cache_geom_pkg::way_t    victim_way;
  logic                    victim_take;

  // The FIFO head drives the Avalon master directly
  assign av_address     = head.address;
  assign av_byte_en     = head.byte_en;
  assign av_read        = head_valid && head.read;
  assign av_write       = head_valid && head.write;
  assign av_wdata       = head.wdata;
  assign av_begin_burst = head.begin_burst;
  assign av_burst_count = head.burst_count;

  xfer_ctrl xfer_ctrl_inst (
    .clk, .rest, .req_kind, .req_address, .req_read, .req_write, .req_wdata,
    .req_byte_en, .tag_read_data, .victim_way, .req_done, .tag_read_set,
    .tag_read_way, .victim_set, .victim_take, .x (xfer.controller)
  );

  victim_select victim_select_inst (
    .clk, .rest, .free_valid, .free_way, .victim_set, .victim_take, .victim_way
  );

  line_mover line_mover_inst (
    .clk, .rest, .data_read_data, .av_read_data, .av_read_data_valid,
    .data_read_addr, .data_read_way, .data_write_addr, .data_write_way,
    .data_write_data, .data_write_en, .tag_write_set, .tag_write_way,
    .tag_write_data, .tag_write_en, .req_rdata,
    .x (xfer.mover), .bus (bus_cmd.producer)
  );

  bus_cmd_fifo bus_cmd_fifo_inst (
    .clk, .rest, .bus (bus_cmd.fifo), .head, .valid (head_valid),
    .pop (!av_wait_request)
  );

endmodule

`default_nettype wire

/* test/tb_mem_model.sv */
`default_nettype none

module tb_mem_model (
  input  logic                      clk,
  input  logic [31:0]               av_address,
  input  logic [3:0]                av_byte_en,
  input  logic                      av_read,
  input  logic                      av_write,
  input  logic [31:0]               av_wdata,
  output logic                      av_wait_request,
  output logic [31:0]               av_read_data,
  output logic                      av_read_data_valid,
  input  logic [8:0]                data_read_addr,
  input  cache_geom_pkg::way_t      data_read_way,
  output logic [31:0]               data_read_data,
  input  logic [8:0]                data_write_addr,
  input  cache_geom_pkg::way_t      data_write_way,
  input  logic [31:0]               data_write_data,
  input  logic                      data_write_en,
  input  cache_geom_pkg::set_t      tag_read_set,
  input  cache_geom_pkg::way_t      tag_read_way,
  output cache_geom_pkg::tag_word_t tag_read_data,
  input  cache_geom_pkg::set_t      tag_write_set,
  input  cache_geom_pkg::way_t      tag_write_way,
  input  cache_geom_pkg::tag_word_t tag_write_data,
  input  logic                      tag_write_en
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_words = 1024;

  logic [31:0]               mem [mem_words];
  logic [31:0]               data_ram [4][512];
  cache_geom_pkg::tag_word_t tag_ram [4][32];
  logic [31:0]               be_mask;

  assign be_mask = {{8{av_byte_en[3]}}, {8{av_byte_en[2]}}, {8{av_byte_en[1]}}, {8{av_byte_en[0]}}};

  // Every preset word depends on its full index, and every tag entry starts valid and dirty
  initial begin
    av_wait_request    <= 1'b0;
    av_read_data       <= '0;
    av_read_data_valid <= 1'b0;
    data_read_data     <= '0;
    tag_read_data      <= '0;
    for (int i = 0; i < mem_words; i++) begin
      mem[10'(i)] <= 32'h1357_0000 ^ (i * 32'h0009_0005);
    end
    for (int i = 0; i < 4 * 512; i++) begin
      data_ram[2'(i / 512)][9'(i % 512)] <= 32'hdada_0000 ^ (i * 32'h0001_0003);
    end
    for (int i = 0; i < 4 * 32; i++) begin
      tag_ram[2'(i / 32)][5'(i % 32)] <=
        cache_geom_pkg::tag_word_t'(32'h0060_0000 | ((i * 32'h0000_0a37) & 32'h001f_ffff));
    end
  end

  // ==========================================================
  // Avalon slave, read data one cycle after acceptance
  // ==========================================================
  always @(posedge clk) begin
    av_wait_request    <= ($urandom % 10) < 3;
    av_read_data_valid <= 1'b0;
    if (av_read && !av_wait_request) begin
      av_read_data       <= mem[av_address[11:2]];
      av_read_data_valid <= 1'b1;
    end
    if (av_write && !av_wait_request) begin
      mem[av_address[11:2]] <= (mem[av_address[11:2]] & ~be_mask) | (av_wdata & be_mask);
    end
  end

  // Data and tag RAMs with a one-cycle synchronous read
  always @(posedge clk) begin
    data_read_data <= data_ram[data_read_way][data_read_addr];
    tag_read_data  <= tag_ram[tag_read_way][tag_read_set];
    if (data_write_en) begin
      data_ram[data_write_way][data_write_addr] <= data_write_data;
    end
    if (tag_write_en) begin
      tag_ram[tag_write_way][tag_write_set] <= tag_write_data;
    end
  end

endmodule

`default_nettype wire

/* test/tb_cache_refill.sv */
`default_nettype none

module tb_cache_refill;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] seed = 32'h1f9b;
  // Eleven requests of at most a few hundred cycles each, with a wide margin
  localparam int max_cycles = 20000;

  logic                      clk = 1'b0;
  logic                      rest;
  cache_geom_pkg::req_kind_t req_kind;
  logic [31:0]               req_address, req_wdata, req_rdata;
  logic                      req_read, req_write, req_done;
  logic [3:0]                req_byte_en;
  logic                      free_valid;
  cache_geom_pkg::way_t      free_way;
  logic [31:0]               av_address, av_wdata, av_read_data;
  logic [3:0]                av_byte_en;
  logic                      av_read, av_write, av_begin_burst;
  logic [4:0]                av_burst_count;
  logic                      av_wait_request, av_read_data_valid;
  logic [8:0]                data_read_addr, data_write_addr;
  cache_geom_pkg::way_t      data_read_way, data_write_way, tag_read_way, tag_write_way;
  logic [31:0]               data_read_data, data_write_data;
  logic                      data_write_en, tag_write_en;
  cache_geom_pkg::set_t      tag_read_set, tag_write_set;
  cache_geom_pkg::tag_word_t tag_read_data, tag_write_data;

  cache_bus_pkg::bus_cmd_t   seen [$];
  int                        done_count = 0;
  int                        cycle_count = 0;
  logic [31:0]               got_rdata;

  cache_refill cache_refill_inst (.*);
  tb_mem_model tb_mem_model_inst (.*);

  always #4 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("error %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  // ==========================================================
  // Bus monitor and run limit
  // ==========================================================
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (req_done) begin
      done_count <= done_count + 1;
    end
    if ((av_read || av_write) && !av_wait_request) begin
      seen.push_back(cache_bus_pkg::bus_cmd_t'{address: av_address, byte_en: av_byte_en,
        read: av_read, write: av_write, wdata: av_wdata, begin_burst: av_begin_burst,
        burst_count: av_burst_count});
    end
    if (cycle_count >= max_cycles) begin
      $display("The run did not finish within %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  assert property (@(posedge clk) disable iff (!rest) req_done |=> !req_done)
    else stop_on_error("req_done stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rest) !(av_read && av_write))
    else stop_on_error("av_read and av_write high together");

  // Holds one request until its done pulse, then returns req_kind to nop
  task automatic run_request(input cache_geom_pkg::req_kind_t kind, input logic [31:0] addr);
    int done_before;
    done_before = done_count;
    seen.delete();
    @(posedge clk);
    req_kind    <= kind;
    req_address <= addr;
    do begin
      @(posedge clk);
    end while (!req_done);
    got_rdata  = req_rdata;
    req_kind   <= cache_geom_pkg::req_nop;
    free_valid <= 1'b0;
    @(posedge clk);
    assert (done_count == done_before + 1)
      else stop_on_error($sformatf("%0d done pulses for one request", done_count - done_before));
  endtask

  task automatic check_burst(input int idx, input logic [31:0] addr, input logic is_write,
                             input logic [31:0] wdata, input logic first);
    cache_bus_pkg::bus_cmd_t c;
    c = seen[idx];
    assert (c.address == addr && c.write == is_write && c.read == !is_write &&
            c.byte_en == 4'hf && c.begin_burst == first && c.burst_count == 5'd16 &&
            (!is_write || c.wdata == wdata))
      else stop_on_error($sformatf("beat %0d got addr %h wr %b data %h, expected %h %b %h",
                                   idx, c.address, c.write, c.wdata, addr, is_write, wdata));
  endtask

  // Fills the line at addr and expects it to land in the given way
  task automatic run_fill(input logic [31:0] addr, input cache_geom_pkg::way_t way,
                          input logic use_free);
    cache_geom_pkg::set_t      line_set;
    cache_geom_pkg::tag_word_t victim;
    logic [31:0]               base;
    logic [31:0]               old_base;
    logic [31:0]               new_words [16];
    logic [31:0]               old_words [16];
    int                        wb;
    line_set = addr[10:6];
    base     = {addr[31:6], 6'h0};
    victim   = tb_mem_model_inst.tag_ram[way][line_set];
    old_base = {victim.tag, line_set, 6'h0};
    wb       = (victim.valid && victim.dirty) ? 16 : 0;
    for (int i = 0; i < 16; i++) begin
      new_words[i] = tb_mem_model_inst.mem[{base[11:6], 4'(i)}];
      old_words[i] = tb_mem_model_inst.data_ram[way][{line_set, 4'(i)}];
    end
    free_valid <= use_free;
    free_way   <= way;
    run_request(cache_geom_pkg::req_fill, addr);
    assert (seen.size() == wb + 16)
      else stop_on_error($sformatf("fill made %0d bus accesses, expected %0d",
                                   seen.size(), wb + 16));
    // Write-back beats must all come before the first read of the new line
    for (int i = 0; i < wb; i++) begin
      check_burst(i, old_base + 32'(4 * i), 1'b1, old_words[i], i == 0);
    end
    for (int i = 0; i < 16; i++) begin
      check_burst(wb + i, base + 32'(4 * i), 1'b0, '0, i == 0);
      assert (tb_mem_model_inst.data_ram[way][{line_set, 4'(i)}] == new_words[i])
        else stop_on_error($sformatf("way %0d set %0d word %0d wrong after fill",
                                     way, line_set, i));
    end
    assert (tb_mem_model_inst.tag_ram[way][line_set] == cache_geom_pkg::tag_word_t'{pad: '0,
            dirty: 1'b0, valid: 1'b1, tag: addr[31:11]})
      else stop_on_error($sformatf("tag of way %0d set %0d wrong after fill", way, line_set));
  endtask

  initial begin
    cache_geom_pkg::tag_word_t victim;
    cache_geom_pkg::set_t      dirty_set;
    logic [31:0]               addr;
    logic [31:0]               wdata;
    logic [3:0]                be;
    void'($urandom(seed));
    rest        <= 1'b0;
    req_kind    <= cache_geom_pkg::req_nop;
    req_address <= '0;
    req_read    <= 1'b0;
    req_write   <= 1'b0;
    req_wdata   <= '0;
    req_byte_en <= '0;
    free_valid  <= 1'b0;
    free_way    <= '0;
    repeat (10) @(posedge clk);
    rest <= 1'b1;
    @(posedge clk);
    assert (!req_done && !av_read && !av_write && !data_write_en && !tag_write_en)
      else stop_on_error("outputs not idle after reset");

    // The preset tag RAM is all dirty, so the first eviction writes back
    dirty_set = 5'($urandom);
    victim    = tb_mem_model_inst.tag_ram[0][dirty_set];
    addr      = {20'h0, !victim.tag[0], dirty_set, 6'h0};
    run_fill(addr, 2'd0, 1'b0);

    run_request(cache_geom_pkg::req_init, '0);
    for (int i = 0; i < 128; i++) begin
      assert (tb_mem_model_inst.tag_ram[2'(i / 32)][5'(i % 32)] == '0)
        else stop_on_error($sformatf("tag entry %0d not cleared by init", i));
    end

    addr  = ($urandom % 1024) << 2;
    wdata = $urandom;
    be    = 4'($urandom % 15 + 1);
    req_write   <= 1'b1;
    req_wdata   <= wdata;
    req_byte_en <= be;
    run_request(cache_geom_pkg::req_io, addr);
    assert (seen.size() == 1 && seen[0].write && !seen[0].read && seen[0].address == addr &&
            seen[0].wdata == wdata && seen[0].byte_en == be)
      else stop_on_error($sformatf("io write to %h was not one matching Avalon write", addr));

    req_write <= 1'b0;
    req_read  <= 1'b1;
    run_request(cache_geom_pkg::req_io, addr);
    assert (seen.size() == 1 && seen[0].read && got_rdata == tb_mem_model_inst.mem[addr[11:2]])
      else stop_on_error($sformatf("io read of %h returned %h, memory holds %h",
                                   addr, got_rdata, tb_mem_model_inst.mem[addr[11:2]]));
    req_read <= 1'b0;

    // Round robin in a fresh set wraps back to way 0 on the fifth fill
    // Each fill carries its own tag so that a wrong way cannot look right
    for (int i = 0; i < 5; i++) begin
      run_fill({18'h0, 3'(i), dirty_set ^ 5'd1, 6'h0}, 2'(i % 4), 1'b0);
    end
    run_fill({20'h0, 1'($urandom), dirty_set ^ 5'd2, 6'h0}, 2'd2, 1'b1);
    run_fill({20'h0, 1'($urandom), dirty_set ^ 5'd2, 6'h0}, 2'd0, 1'b0);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/cache_geom_pkg.sv
logic/cache_bus_pkg.sv
logic/cache_if.sv
logic/bus_cmd_fifo.sv
logic/victim_select.sv
logic/xfer_ctrl.sv
logic/line_mover.sv
logic/cache_refill.sv
test/tb_mem_model.sv
test/tb_cache_refill.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module tb_cache_refill -o tb_cache_refill &&
  ./obj_dir/tb_cache_refill ||
  { echo "Simulation build or run reported a failure"; exit 1; }
